//--- Bender.yml
package:
  name: sram_bridge

sources:
  - logic/mips_pkg.sv
  - logic/bus_pkg.sv
  - logic/cpu_port_slave.sv
  - logic/seg_map_arbiter.sv
  - logic/mem_bus_master.sv
  - logic/sram_bridge_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_sram_bridge.sv

//--- list.f
+incdir+verification
logic/mips_pkg.sv
logic/bus_pkg.sv
logic/cpu_port_slave.sv
logic/seg_map_arbiter.sv
logic/mem_bus_master.sv
logic/sram_bridge_top.sv
verification/tb_sram_bridge.sv

//--- logic/bus_pkg.sv
package bus_pkg;

    import mips_pkg::*;

    // one request as held by a port slot
    typedef struct packed {
        logic   wr;
        size_t  size;
        vaddr_u addr;
        word_t  wdata;
    } cpu_req_t;

    // which cpu port owns a request
    typedef enum logic {
        PORT_INST = 1'b0,
        PORT_DATA = 1'b1
    } port_sel_t;

    // what the master presents on the memory bus while mem_req is high
    typedef struct packed {
        logic       wr;
        logic [3:0] be;
        word_t      addr;   // physical
        word_t      wdata;
    } mem_txn_t;

    // arbiter to master, valid is a one-cycle pulse
    typedef struct packed {
        logic      valid;
        port_sel_t port;
        cpu_req_t  req;    // address already mapped
    } grant_t;

    // byte lane patterns, shifted by the low address bits
    localparam logic [3:0] BE_BYTE0 = 4'b0001;
    localparam logic [3:0] BE_HALF0 = 4'b0011;
    localparam logic [3:0] BE_ALL   = 4'b1111;

endpackage

//--- logic/cpu_port_slave.sv
`timescale 1ns/1ns

module cpu_port_slave
    import mips_pkg::*, bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // sram-like side
    input  logic     req,
    input  logic     wr,
    input  size_t    size,
    input  word_t    addr,
    input  word_t    wdata,
    output logic     addr_ok,
    output logic     data_ok,
    output word_t    rdata,

    // arbiter side
    output logic     pend,
    output cpu_req_t held,
    input  logic     taken,
    input  logic     done,
    input  word_t    done_rdata
);

    typedef enum logic [1:0] {
        SLOT_EMPTY  = 2'd0,
        SLOT_PEND   = 2'd1,
        SLOT_FLIGHT = 2'd2
    } slot_state_t;

    slot_state_t state;
    slot_state_t state_nxt;
    logic        accept;
    logic        finish;

    assign addr_ok = (state == SLOT_EMPTY);
    assign pend    = (state == SLOT_PEND);
    assign accept  = req & addr_ok;
    assign finish  = done & (state == SLOT_FLIGHT);

    always_comb begin
        state_nxt = state;
        case (state)
            SLOT_EMPTY: begin
                if (accept) begin
                    state_nxt = SLOT_PEND;
                end
            end
            SLOT_PEND: begin
                if (taken) begin
                    state_nxt = SLOT_FLIGHT;   // arbiter has copied the request
                end
            end
            SLOT_FLIGHT: begin
                if (done) begin
                    state_nxt = SLOT_EMPTY;    // free again in the data_ok cycle
                end
            end
            default: begin
                state_nxt = SLOT_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= SLOT_EMPTY;
            data_ok <= 1'b0;
        end else begin
            state   <= state_nxt;
            data_ok <= finish;
        end
    end

    // request fields, only loaded on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            held.wr       <= wr;
            held.size     <= size;
            held.addr.raw <= addr;
            held.wdata    <= wdata;
        end
    end

    // read data for the data_ok cycle, zero on writes
    always_ff @(posedge clk) begin
        if (finish) begin
            rdata <= held.wr ? '0 : done_rdata;
        end
    end

endmodule

//--- logic/mem_bus_master.sv
`timescale 1ns/1ns

module mem_bus_master
    import mips_pkg::*, bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  grant_t   grant,
    output logic     busy,
    output logic     done,
    output word_t    done_rdata,

    output logic     mem_req,
    output mem_txn_t mem_txn,
    input  logic     mem_ack,
    input  word_t    mem_rdata
);

    typedef enum logic [1:0] {
        M_IDLE     = 2'd0,
        M_REQ      = 2'd1,   // mem_req high, waiting for ack
        M_DONE     = 2'd2,   // req dropped, done pulse
        M_ACK_LOW  = 2'd3    // memory still holding ack
    } master_state_t;

    master_state_t state;
    master_state_t state_nxt;
    logic [3:0]    be;
    logic          start;

    assign start = (state == M_IDLE) & grant.valid;

    // lanes from size and the low address bits, accesses are aligned
    always_comb begin
        case (grant.req.size)
            SIZE_BYTE: be = BE_BYTE0 << grant.req.addr.raw[1:0];
            SIZE_HALF: be = grant.req.addr.raw[1] ? (BE_HALF0 << 2) : BE_HALF0;
            SIZE_WORD: be = BE_ALL;
            default:   be = BE_ALL;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            M_IDLE: begin
                if (grant.valid) begin
                    state_nxt = M_REQ;
                end
            end
            M_REQ: begin
                if (mem_ack) begin
                    state_nxt = M_DONE;
                end
            end
            M_DONE: begin
                state_nxt = mem_ack ? M_ACK_LOW : M_IDLE;
            end
            M_ACK_LOW: begin
                if (!mem_ack) begin
                    state_nxt = M_IDLE;
                end
            end
            default: begin
                state_nxt = M_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= M_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // transaction is frozen from grant until the next one
    always_ff @(posedge clk) begin
        if (start) begin
            mem_txn.wr    <= grant.req.wr;
            mem_txn.be    <= be;
            mem_txn.addr  <= grant.req.addr.raw;
            mem_txn.wdata <= grant.req.wdata;   // lanes already placed by the core
        end
    end

    always_ff @(posedge clk) begin
        if ((state == M_REQ) && mem_ack) begin
            done_rdata <= mem_rdata;
        end
    end

    assign mem_req = (state == M_REQ);
    assign done    = (state == M_DONE);
    assign busy    = (state != M_IDLE);

endmodule

//--- logic/mips_pkg.sv
package mips_pkg;

    // plain cpu word, also used for addresses
    typedef logic [31:0] word_t;

    // access size as driven by the core on inst_size / data_size
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // virtual address split into segment bits and the low offset
    typedef struct packed {
        logic [2:0]  seg;   // va[31:29]
        logic [28:0] off;   // va[28:0]
    } seg_addr_t;

    // the same address word read plainly or as segment plus offset
    typedef union packed {
        word_t     raw;
        seg_addr_t seg;
    } vaddr_u;

    // va[31:30] == 2'b10 covers kseg0 and kseg1 (top nibble 8..b)
    localparam logic [1:0] KSEG_MAPPED_HI = 2'b10;

    // segment bits after unmapped translation
    localparam logic [2:0] SEG_CLEAR = 3'b000;

endpackage

//--- logic/seg_map_arbiter.sv
`timescale 1ns/1ns

module seg_map_arbiter
    import mips_pkg::*, bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     inst_pend,
    input  logic     data_pend,
    input  cpu_req_t inst_held,
    input  cpu_req_t data_held,
    output logic     inst_taken,
    output logic     data_taken,
    output logic     inst_done,
    output logic     data_done,

    output grant_t   grant,
    input  logic     master_busy,
    input  logic     master_done
);

    logic      issue;
    port_sel_t sel;
    cpu_req_t  chosen;
    cpu_req_t  mapped;

    // a grant pulse already on the wire counts as busy
    assign issue = (inst_pend | data_pend) & ~master_busy & ~grant.valid;

    // data port first
    assign sel    = data_pend ? PORT_DATA : PORT_INST;
    assign chosen = (sel == PORT_DATA) ? data_held : inst_held;

    assign data_taken = issue & (sel == PORT_DATA);
    assign inst_taken = issue & (sel == PORT_INST);

    // kseg0/kseg1 drop va[31:29], all other segments pass through
    always_comb begin
        mapped = chosen;
        if (chosen.addr.seg.seg[2:1] == KSEG_MAPPED_HI) begin
            mapped.addr.seg.seg = SEG_CLEAR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant.valid <= 1'b0;
        end else begin
            grant.valid <= issue;
        end
    end

    // port and request stay put until the next issue,
    // so grant.port names the owner of the transaction in flight
    always_ff @(posedge clk) begin
        if (issue) begin
            grant.port <= sel;
            grant.req  <= mapped;
        end
    end

    assign data_done = master_done & (grant.port == PORT_DATA);
    assign inst_done = master_done & (grant.port == PORT_INST);

endmodule

//--- logic/sram_bridge_top.sv
`timescale 1ns/1ns

module sram_bridge_top
    import mips_pkg::*, bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // instruction port
    input  logic     inst_req,
    input  logic     inst_wr,
    input  size_t    inst_size,
    input  word_t    inst_addr,
    input  word_t    inst_wdata,
    output logic     inst_addr_ok,
    output logic     inst_data_ok,
    output word_t    inst_rdata,

    // data port
    input  logic     data_req,
    input  logic     data_wr,
    input  size_t    data_size,
    input  word_t    data_addr,
    input  word_t    data_wdata,
    output logic     data_addr_ok,
    output logic     data_data_ok,
    output word_t    data_rdata,

    // shared memory bus
    output logic     mem_req,
    output mem_txn_t mem_txn,
    input  logic     mem_ack,
    input  word_t    mem_rdata
);

    logic     inst_pend, data_pend;
    cpu_req_t inst_held, data_held;
    logic     inst_taken, data_taken;
    logic     inst_done, data_done;
    grant_t   grant;
    logic     master_busy;
    logic     master_done;
    word_t    master_rdata;

    cpu_port_slave inst_port_i (
        .clk, .rst,
        .req(inst_req), .wr(inst_wr), .size(inst_size), .addr(inst_addr),
        .wdata(inst_wdata), .addr_ok(inst_addr_ok), .data_ok(inst_data_ok),
        .rdata(inst_rdata),
        .pend(inst_pend), .held(inst_held), .taken(inst_taken),
        .done(inst_done), .done_rdata(master_rdata)
    );

    cpu_port_slave data_port_i (
        .clk, .rst,
        .req(data_req), .wr(data_wr), .size(data_size), .addr(data_addr),
        .wdata(data_wdata), .addr_ok(data_addr_ok), .data_ok(data_data_ok),
        .rdata(data_rdata),
        .pend(data_pend), .held(data_held), .taken(data_taken),
        .done(data_done), .done_rdata(master_rdata)
    );

    seg_map_arbiter arbiter_i (
        .clk, .rst,
        .inst_pend, .data_pend, .inst_held, .data_held,
        .inst_taken, .data_taken, .inst_done, .data_done,
        .grant, .master_busy, .master_done
    );

    mem_bus_master master_i (
        .clk, .rst,
        .grant, .busy(master_busy), .done(master_done), .done_rdata(master_rdata),
        .mem_req, .mem_txn, .mem_ack, .mem_rdata
    );

endmodule

//--- verification/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int    err_txn;
int    err_rdata;
int    err_flag;
int    err_proto;

word_t shadow [64];       // memory as the bridge should leave it, in grant order
word_t inst_exp_q [$];
word_t data_exp_q [$];

function automatic word_t fill_word(input int idx);
    word_t w;
    w = idx + 1;
    return w * 32'h9e37_79b9;   // spreads the word index over all lanes
endfunction

// kseg0/kseg1 (top nibble 8..b) lose va[31:29]
function automatic word_t map_addr(input word_t va);
    case (va[31:28])
        4'h8, 4'h9, 4'ha, 4'hb: return va & 32'h1fff_ffff;
        default:                return va;
    endcase
endfunction

function automatic logic [3:0] lane_enables(input size_t sz, input logic [1:0] lo);
    logic [3:0] be;
    int         nbytes;
    be = '0;
    case (sz)
        SIZE_BYTE: nbytes = 1;
        SIZE_HALF: nbytes = 2;
        default:   nbytes = 4;
    endcase
    for (int b = 0; b < 4; b++) begin
        if (b >= lo && b < lo + nbytes) begin
            be[b] = 1'b1;   // lanes lo up to lo + nbytes - 1
        end
    end
    return be;
endfunction

function automatic word_t merge_lanes(input word_t old, input word_t nw, input logic [3:0] be);
    word_t w;
    w = old;
    for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
            w[8*b +: 8] = nw[8*b +: 8];
        end
    end
    return w;
endfunction

function automatic mem_txn_t expect_txn(input cpu_req_t r);
    mem_txn_t t;
    t.wr    = r.wr;
    t.be    = lane_enables(r.size, r.addr.raw[1:0]);
    t.addr  = map_addr(r.addr.raw);
    t.wdata = r.wdata;
    return t;
endfunction

// shadow update and the read data the owning port should see
task automatic apply_grant(input port_sel_t p, input mem_txn_t t);
    word_t rd;
    rd = t.wr ? '0 : shadow[t.addr[7:2]];
    if (t.wr) begin
        shadow[t.addr[7:2]] = merge_lanes(shadow[t.addr[7:2]], t.wdata, t.be);
    end
    if (p == PORT_DATA) begin
        data_exp_q.push_back(rd);
    end else begin
        inst_exp_q.push_back(rd);
    end
endtask

task automatic take_expected(input int p, output logic found, output word_t w);
    found = 1'b0;
    w     = '0;
    if (p == PORT_DATA && data_exp_q.size() > 0) begin
        found = 1'b1;
        w     = data_exp_q.pop_front();
    end else if (p == PORT_INST && inst_exp_q.size() > 0) begin
        found = 1'b1;
        w     = inst_exp_q.pop_front();
    end
endtask

task automatic check_txn(input string name, input mem_txn_t exp, input mem_txn_t got);
    if (got !== exp) begin
        $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
        err_txn++;
    end
endtask

task automatic check_rdata(input string name, input word_t exp, input word_t got);
    if (got !== exp) begin
        $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
        err_rdata++;
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
        $display("ERR %0t %s exp=%b got=%b", $time, name, exp, got);
        err_flag++;
    end
endtask

task automatic report_fault(input string msg);
    $display("%0t: %s", $time, msg);
    err_proto++;
endtask

`endif

//--- verification/tb_sram_bridge.sv
`timescale 1ns/1ns

module tb_sram_bridge
    import mips_pkg::*, bus_pkg::*;
();

    localparam int REQ_PER_PORT = 150;
    localparam int TXN_WORST    = 10;   // one bus transaction, 3-cycle ack delay and 3-cycle hold
    localparam int CYCLE_LIMIT  = 2 * (2 * REQ_PER_PORT) * TXN_WORST;
    localparam int DRV          = 2;

    logic        clk;
    logic        rst;
    logic  [1:0] port_req, port_wr, addr_ok, data_ok;
    size_t [1:0] port_size;
    word_t [1:0] port_addr, port_wdata, rdata;
    logic        mem_req;
    logic        mem_ack;
    mem_txn_t    mem_txn;
    word_t       mem_rdata;

    logic [15:0] lfsr;
    int          cyc = 0;
    int          issued [2];
    logic  [1:0] accepted, busy, cand_valid;
    cpu_req_t    cand_req [2];
    int          cand_cyc [2];   // edge on which the request was accepted
    mem_txn_t    cur_txn;
    logic        prev_req, prev_ack;
    word_t       mem_array [64];
    logic        armed;
    logic [1:0]  ack_delay;

    `include "tb_checks.svh"

    sram_bridge_top dut_i (
        .clk, .rst,
        .inst_req(port_req[PORT_INST]), .inst_wr(port_wr[PORT_INST]),
        .inst_size(port_size[PORT_INST]), .inst_addr(port_addr[PORT_INST]),
        .inst_wdata(port_wdata[PORT_INST]), .inst_addr_ok(addr_ok[PORT_INST]),
        .inst_data_ok(data_ok[PORT_INST]), .inst_rdata(rdata[PORT_INST]),
        .data_req(port_req[PORT_DATA]), .data_wr(port_wr[PORT_DATA]),
        .data_size(port_size[PORT_DATA]), .data_addr(port_addr[PORT_DATA]),
        .data_wdata(port_wdata[PORT_DATA]), .data_addr_ok(addr_ok[PORT_DATA]),
        .data_data_ok(data_ok[PORT_DATA]), .data_rdata(rdata[PORT_DATA]),
        .mem_req, .mem_txn, .mem_ack, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        wait (cyc >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, accepted inst %0d data %0d",
                 cyc, issued[0], issued[1]);
        $display(">>> FAIL");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // the arbiter decides two cycles before mem_req rises
    function automatic logic eligible(input port_sel_t p);
        return cand_valid[p] && cand_cyc[p] <= cyc - 2;
    endfunction

    task automatic drive_port(input int p);
        logic [2:0] pick;
        logic [3:0] nib;
        size_t      sz;
        logic [1:0] lo;
        logic [5:0] widx;
        if (port_req[p] && !accepted[p]) begin
            return;   // held until addr_ok
        end
        port_req[p] = 1'b0;
        accepted[p] = 1'b0;
        if (issued[p] >= REQ_PER_PORT || rand_bits(2) == 2'd0) begin
            return;
        end
        pick = rand_bits(3);
        nib  = rand_bits(4);
        if (pick < 3'd4) begin
            nib = 4'h8 + pick;          // kseg0/kseg1
        end else if (nib[3:2] == 2'b10) begin
            nib[3:2] = 2'b11;
        end
        sz = rand_bits(2);
        if (sz == 2'd3) sz = SIZE_WORD;
        lo   = rand_bits(2);
        widx = rand_bits(6);
        if (sz == SIZE_HALF) lo[0] = 1'b0;
        if (sz == SIZE_WORD) lo = 2'b00;
        port_req[p]   = 1'b1;
        port_wr[p]    = rand_bits(1);
        port_size[p]  = sz;
        port_addr[p]  = {nib, 20'h3a5c1, widx, lo};
        port_wdata[p] = rand_bits(32);
    endtask

    task automatic respond_mem();
        logic [5:0] idx;
        idx = mem_txn.addr[7:2];
        if (mem_ack && !mem_req) begin
            if (!armed) begin
                armed     = 1'b1;
                ack_delay = rand_bits(2);   // ack held a few cycles after req drops
            end
            if (ack_delay == 2'd0) begin
                mem_ack   = 1'b0;
                mem_rdata = '0;
                armed     = 1'b0;
            end else begin
                ack_delay = ack_delay - 1'b1;
            end
        end else if (mem_req && !mem_ack) begin
            if (!armed) begin
                armed     = 1'b1;
                ack_delay = rand_bits(2);
            end
            if (ack_delay == 2'd0) begin
                if (mem_txn.wr) begin
                    mem_array[idx] = merge_lanes(mem_array[idx], mem_txn.wdata, mem_txn.be);
                end
                mem_rdata = mem_array[idx];
                mem_ack   = 1'b1;
                armed     = 1'b0;
            end else begin
                ack_delay = ack_delay - 1'b1;
            end
        end
    endtask

    task automatic watch_cycle();
        port_sel_t own;
        logic      found;
        word_t     want;
        for (int p = 0; p < 2; p++) begin
            check_flag(p ? "data_addr_ok" : "inst_addr_ok", !busy[p] || data_ok[p], addr_ok[p]);
            if (data_ok[p]) begin
                take_expected(p, found, want);
                if (!found) begin
                    report_fault(p ? "data_ok on data port without an accepted request"
                                   : "data_ok on inst port without an accepted request");
                end else begin
                    check_rdata(p ? "data_rdata" : "inst_rdata", want, rdata[p]);
                end
                busy[p] = 1'b0;
            end
            if (port_req[p] && addr_ok[p]) begin
                accepted[p]   = 1'b1;
                busy[p]       = 1'b1;
                issued[p]++;
                cand_valid[p] = 1'b1;
                cand_cyc[p]   = cyc + 1;
                cand_req[p]   = {port_wr[p], port_size[p], port_addr[p], port_wdata[p]};
            end
        end
        if (mem_req && !prev_req) begin
            if (prev_ack) report_fault("mem_req raised while mem_ack was still high");
            own = eligible(PORT_DATA) ? PORT_DATA : PORT_INST;
            if (!eligible(own)) begin
                report_fault("bus transaction without an eligible request");
            end else begin
                cur_txn         = expect_txn(cand_req[own]);
                cand_valid[own] = 1'b0;
                apply_grant(own, cur_txn);
            end
        end
        if (mem_req) check_txn("mem_txn", cur_txn, mem_txn);   // also held stable
        if (!mem_req && prev_req && !prev_ack) report_fault("mem_req dropped before mem_ack");
        prev_req = mem_req;
        prev_ack = mem_ack;
    endtask

    always @(negedge clk) begin
        if (!rst) watch_cycle();
    end

    initial begin
        lfsr       = 16'd39181;
        port_req   = '0;
        port_wr    = '0;
        port_size  = '0;
        port_addr  = '0;
        port_wdata = '0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        accepted   = '0;
        busy       = '0;
        cand_valid = '0;
        armed      = 1'b0;
        ack_delay  = '0;
        prev_req   = 1'b0;
        prev_ack   = 1'b0;
        for (int i = 0; i < 64; i++) begin
            shadow[i]    = fill_word(i);
            mem_array[i] = fill_word(i);
        end
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #DRV rst = 1'b0;
        @(negedge clk);
        check_flag("mem_req", 1'b0, mem_req);
        check_flag("inst_data_ok", 1'b0, data_ok[PORT_INST]);
        check_flag("data_data_ok", 1'b0, data_ok[PORT_DATA]);
        check_flag("inst_addr_ok", 1'b1, addr_ok[PORT_INST]);
        check_flag("data_addr_ok", 1'b1, addr_ok[PORT_DATA]);
        while (issued[0] < REQ_PER_PORT || issued[1] < REQ_PER_PORT || busy != 2'b00) begin
            @(posedge clk);
            #DRV;
            drive_port(PORT_INST);
            drive_port(PORT_DATA);
            respond_mem();
        end
        repeat (4) begin
            @(posedge clk);
            #DRV;
            respond_mem();
        end
        if (inst_exp_q.size() != 0 || data_exp_q.size() != 0 || cand_valid != 2'b00) begin
            report_fault("requests left without completion");
        end
        $display("errors: txn %0d, rdata %0d, flag %0d, protocol %0d",
                 err_txn, err_rdata, err_flag, err_proto);
        if (err_txn + err_rdata + err_flag + err_proto == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
